// ==== regman_cfg.svh ====
`ifndef REGMAN_CFG_SVH
`define REGMAN_CFG_SVH

// data word width, registers and memory words alike
`define REGMAN_DATA_W 16

// memory address width
// address sums wrap modulo 256
`define REGMAN_ADDR_W 8

// register number width, 16 registers per process
`define REGMAN_REG_NUM_W 4

// cycles from a bus strobe to its done pulse
// must be 1 or more
`define REGMAN_MEM_LAT 3

`endif

// ==== regman_pkg.sv ====
package regman_pkg;

  // register operation, sequencer to manager
  // held as a level for the whole operation
  typedef enum logic [2:0] {
    // nothing in flight, manager re-arms
    REG_OP_IDLE       = 3'd0,
    // read the register word at base + reg
    REG_OP_READ       = 3'd1,
    // read the word the register points to
    REG_OP_READ_P     = 3'd2,
    // build the post-inc/dec value, no bus access
    REG_OP_WRITE_PREP = 3'd3,
    // write back to base + reg
    REG_OP_WRITE      = 3'd4,
    // write store data through the pointer
    REG_OP_WRITE_P    = 3'd5
  } reg_op_e;

  // command opcode
  typedef enum logic {
    CMD_FETCH = 1'b0,
    CMD_STORE = 1'b1
  } cmd_op_e;

  // operand sequencer states
  typedef enum logic [2:0] {
    SEQ_IDLE   = 3'd0,
    SEQ_READ   = 3'd1,
    // pointer access, read for fetch, write for store
    SEQ_READ_P = 3'd2,
    SEQ_PREP   = 3'd3,
    SEQ_WRITE  = 3'd4,
    SEQ_DONE   = 3'd5
  } seq_state_e;

endpackage

// ==== operand_sequencer.sv ====
`include "regman_cfg.svh"

module operand_sequencer
  import regman_pkg::*;
(
  input  logic                         clk,
  input  logic                         rst,
  input  logic                         start,
  input  cmd_op_e                      cmd_op,
  input  logic [`REGMAN_ADDR_W-1:0]    base_addr,
  input  logic [`REGMAN_REG_NUM_W-1:0] reg_num,
  input  logic                         is_ptr,
  input  logic [1:0]                   post_flags,
  input  logic [`REGMAN_DATA_W-1:0]    store_data,
  input  logic                         op_done,
  input  logic [`REGMAN_DATA_W-1:0]    caught_value,
  output reg_op_e                      reg_op,
  output logic [`REGMAN_ADDR_W-1:0]    lat_base,
  output logic [`REGMAN_REG_NUM_W-1:0] lat_reg,
  output logic                         lat_ptr,
  output logic [1:0]                   lat_flags,
  output logic [`REGMAN_DATA_W-1:0]    lat_store,
  output logic                         busy,
  output logic                         done,
  output logic [`REGMAN_DATA_W-1:0]    result
);

  seq_state_e state;
  cmd_op_e    lat_op;
  logic       accept;
  logic       flags_set;

  // busy is low only in idle
  assign accept = start && !busy;
  // 01 or 10 means a write-back is due
  assign flags_set = ^lat_flags;

  // one reg op per state
  always_comb begin
    case (state)
      SEQ_READ:   reg_op = REG_OP_READ;
      SEQ_READ_P: begin
        // store goes through the pointer as a write
        if (lat_op == CMD_STORE) begin
          reg_op = REG_OP_WRITE_P;
        end else begin
          reg_op = REG_OP_READ_P;
        end
      end
      SEQ_PREP:   reg_op = REG_OP_WRITE_PREP;
      SEQ_WRITE:  reg_op = REG_OP_WRITE;
      default:    reg_op = REG_OP_IDLE;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= SEQ_IDLE;
      busy  <= 1'b0;
      done  <= 1'b0;
    end else begin
      done <= 1'b0;
      case (state)
        SEQ_IDLE: begin
          if (accept) begin
            busy <= 1'b1;
            // direct store needs no read at all
            if (cmd_op == CMD_STORE && !is_ptr) begin
              state <= SEQ_WRITE;
            end else begin
              state <= SEQ_READ;
            end
          end
        end
        SEQ_READ: begin
          if (op_done) begin
            if (lat_ptr) begin
              state <= SEQ_READ_P;
            end else if (flags_set) begin
              state <= SEQ_PREP;
            end else begin
              state <= SEQ_DONE;
            end
          end
        end
        SEQ_READ_P: begin
          // pointer update goes straight to write
          if (op_done) begin
            state <= flags_set ? SEQ_WRITE : SEQ_DONE;
          end
        end
        SEQ_PREP: begin
          if (op_done) begin
            state <= SEQ_WRITE;
          end
        end
        SEQ_WRITE: begin
          if (op_done) begin
            state <= SEQ_DONE;
          end
        end
        SEQ_DONE: begin
          // done and busy low land in the same cycle
          state <= SEQ_IDLE;
          busy  <= 1'b0;
          done  <= 1'b1;
        end
        default: state <= SEQ_IDLE;
      endcase
    end
  end

  // command latch and result hold
  always_ff @(posedge clk) begin
    if (state == SEQ_IDLE && accept) begin
      lat_op    <= cmd_op;
      lat_base  <= base_addr;
      lat_reg   <= reg_num;
      lat_ptr   <= is_ptr;
      lat_flags <= post_flags;
      lat_store <= store_data;
    end
    if (state == SEQ_DONE) begin
      result <= (lat_op == CMD_STORE) ? lat_store : caught_value;
    end
  end

endmodule

// ==== register_manager.sv ====
`include "regman_cfg.svh"

module register_manager
  import regman_pkg::*;
(
  input  logic                         clk,
  input  logic                         rst,
  input  reg_op_e                      reg_op,
  input  logic [`REGMAN_ADDR_W-1:0]    base_addr,
  input  logic [`REGMAN_REG_NUM_W-1:0] reg_num,
  input  logic                         is_ptr,
  input  logic [1:0]                   post_flags,
  input  logic [`REGMAN_DATA_W-1:0]    store_data,
  input  logic                         read_dn,
  input  logic                         write_dn,
  input  logic [`REGMAN_DATA_W-1:0]    rdata,
  input  logic                         bus_busy,
  output logic                         read_q,
  output logic                         write_q,
  output logic [`REGMAN_ADDR_W-1:0]    addr,
  output logic [`REGMAN_DATA_W-1:0]    wdata,
  output logic                         op_done,
  output logic [`REGMAN_DATA_W-1:0]    caught_value
);

  localparam int data_w = `REGMAN_DATA_W;
  localparam int addr_w = `REGMAN_ADDR_W;

  // register word as caught, data word after read_p
  logic [data_w-1:0] reg_val;
  // pointer as read from the register
  logic [data_w-1:0] ptr_val;
  // direct write-back value built in write_prep
  logic [data_w-1:0] save_val;

  // one strobe per operation
  logic single;
  // strobe out, done not yet seen
  logic waiting;
  // write_prep ran in this command
  logic prepped;

  logic [addr_w-1:0] reg_addr;
  logic [addr_w-1:0] ptr_addr;
  logic [addr_w-1:0] target_addr;
  logic [data_w-1:0] write_val;
  logic              is_access;
  logic              is_read;
  logic              issue;
  logic              hit;

  // 01 up, 10 down, anything else leaves it
  function automatic logic [data_w-1:0] post_update(input logic [data_w-1:0] value,
                                                    input logic [1:0]        flags);
    case (flags)
      2'b01:   post_update = value + data_w'(1);
      2'b10:   post_update = value - data_w'(1);
      default: post_update = value;
    endcase
  endfunction

  // register and pointed-to addresses, both wrap
  assign reg_addr = base_addr + addr_w'(reg_num);
  assign ptr_addr = base_addr + ptr_val[addr_w-1:0];

  assign is_access = (reg_op == REG_OP_READ) || (reg_op == REG_OP_READ_P) ||
                     (reg_op == REG_OP_WRITE) || (reg_op == REG_OP_WRITE_P);
  assign is_read   = (reg_op == REG_OP_READ) || (reg_op == REG_OP_READ_P);

  always_comb begin
    if (reg_op == REG_OP_READ_P || reg_op == REG_OP_WRITE_P) begin
      target_addr = ptr_addr;
    end else begin
      target_addr = reg_addr;
    end
  end

  // write data by operation and command kind
  always_comb begin
    if (reg_op == REG_OP_WRITE_P) begin
      write_val = store_data;
    end else if (is_ptr) begin
      // pointer write-back after read_p or write_p
      write_val = post_update(ptr_val, post_flags);
    end else if (prepped) begin
      // direct fetch with post flags
      write_val = save_val;
    end else begin
      // direct store
      write_val = store_data;
    end
  end

  assign issue = is_access && single && !bus_busy;

  // done counts only on our own address
  assign hit = waiting && (addr == target_addr) && (is_read ? read_dn : write_dn);

  assign caught_value = reg_val;

  always_ff @(posedge clk) begin
    if (rst) begin
      read_q  <= 1'b0;
      write_q <= 1'b0;
      op_done <= 1'b0;
      single  <= 1'b1;
      waiting <= 1'b0;
      prepped <= 1'b0;
    end else begin
      read_q  <= 1'b0;
      write_q <= 1'b0;
      op_done <= 1'b0;
      // next reg op shows up after op_done
      if (op_done) begin
        single <= 1'b1;
      end
      if (reg_op == REG_OP_IDLE) begin
        single  <= 1'b1;
        prepped <= 1'b0;
      end
      // prep takes no bus cycle
      if (reg_op == REG_OP_WRITE_PREP && !op_done) begin
        prepped <= 1'b1;
        op_done <= 1'b1;
      end
      if (issue) begin
        read_q  <= is_read;
        write_q <= !is_read;
        single  <= 1'b0;
        waiting <= 1'b1;
      end else if (hit) begin
        waiting <= 1'b0;
        op_done <= 1'b1;
      end
    end
  end

  // request payload and caught values
  always_ff @(posedge clk) begin
    if (issue) begin
      addr  <= target_addr;
      wdata <= write_val;
    end
    if (hit && reg_op == REG_OP_READ) begin
      reg_val <= rdata;
      ptr_val <= rdata;
    end
    if (hit && reg_op == REG_OP_READ_P) begin
      reg_val <= rdata;
    end
    if (reg_op == REG_OP_WRITE_PREP) begin
      save_val <= post_update(reg_val, post_flags);
    end
  end

endmodule

// ==== bus_port.sv ====
`include "regman_cfg.svh"

module bus_port (
  input  logic                      clk,
  input  logic                      rst,
  input  logic                      read_q,
  input  logic                      write_q,
  input  logic [`REGMAN_ADDR_W-1:0] addr,
  input  logic [`REGMAN_DATA_W-1:0] wdata,
  input  logic [`REGMAN_DATA_W-1:0] mem_rdata,
  output logic                      read_dn,
  output logic                      write_dn,
  output logic [`REGMAN_DATA_W-1:0] rdata,
  output logic                      bus_busy,
  output logic                      mem_we,
  output logic [`REGMAN_ADDR_W-1:0] mem_addr,
  output logic [`REGMAN_DATA_W-1:0] mem_wdata
);

  localparam int lat   = `REGMAN_MEM_LAT;
  localparam int cnt_w = $clog2(lat + 1);
  // with latency 1 the access happens in the strobe cycle
  localparam bit lat_one = (lat == 1);

  logic                      pending;
  logic [cnt_w-1:0]          cnt;
  logic                      req_wr;
  logic [`REGMAN_ADDR_W-1:0] req_addr;
  logic [`REGMAN_DATA_W-1:0] req_data;

  logic issue;
  logic access_now;
  logic finish;

  assign issue = read_q || write_q;

  // memory is touched one cycle before done
  // so the sync read lands in the done cycle
  assign access_now = (lat_one && issue) || (pending && cnt == cnt_w'(1));
  assign finish     = pending && cnt == '0;

  // latched request once pending, live strobe before
  assign mem_addr  = pending ? req_addr : addr;
  assign mem_wdata = pending ? req_data : wdata;
  assign mem_we    = access_now && (pending ? req_wr : write_q);

  assign read_dn  = finish && !req_wr;
  assign write_dn = finish && req_wr;
  assign rdata    = mem_rdata;
  assign bus_busy = pending;

  always_ff @(posedge clk) begin
    if (rst) begin
      pending <= 1'b0;
      cnt     <= '0;
    end else begin
      if (issue && !pending) begin
        pending <= 1'b1;
        cnt     <= cnt_w'(lat - 1);
      end else if (finish) begin
        pending <= 1'b0;
      end else if (pending) begin
        cnt <= cnt - 1'b1;
      end
    end
  end

  // request payload
  always_ff @(posedge clk) begin
    if (issue && !pending) begin
      req_wr   <= write_q;
      req_addr <= addr;
      req_data <= wdata;
    end
  end

endmodule

// ==== register_memory.sv ====
`include "regman_cfg.svh"

module register_memory (
  input  logic                      clk,
  input  logic                      host_we,
  input  logic [`REGMAN_ADDR_W-1:0] host_addr,
  input  logic [`REGMAN_DATA_W-1:0] host_wdata,
  input  logic                      mem_we,
  input  logic [`REGMAN_ADDR_W-1:0] mem_addr,
  input  logic [`REGMAN_DATA_W-1:0] mem_wdata,
  output logic [`REGMAN_DATA_W-1:0] host_rdata,
  output logic [`REGMAN_DATA_W-1:0] mem_rdata
);

  localparam int depth = 1 << `REGMAN_ADDR_W;

  // process registers and data share this array
  logic [`REGMAN_DATA_W-1:0] mem [depth];

  always_ff @(posedge clk) begin
    // host port, preload and check while idle
    if (host_we) begin
      mem[host_addr] <= host_wdata;
    end
    // bus port
    // same-address collision leaves the bus word
    if (mem_we) begin
      mem[mem_addr] <= mem_wdata;
    end
    // both reads return the old word
    host_rdata <= mem[host_addr];
    mem_rdata  <= mem[mem_addr];
  end

endmodule

// ==== regman_top.sv ====
`include "regman_cfg.svh"

module regman_top
  import regman_pkg::*;
(
  input  logic                         clk,
  input  logic                         rst,
  input  logic                         start,
  input  cmd_op_e                      cmd_op,
  input  logic [`REGMAN_ADDR_W-1:0]    base_addr,
  input  logic [`REGMAN_REG_NUM_W-1:0] reg_num,
  input  logic                         is_ptr,
  input  logic [1:0]                   post_flags,
  input  logic [`REGMAN_DATA_W-1:0]    store_data,
  output logic                         busy,
  output logic                         done,
  output logic [`REGMAN_DATA_W-1:0]    result,
  input  logic                         host_we,
  input  logic [`REGMAN_ADDR_W-1:0]    host_addr,
  input  logic [`REGMAN_DATA_W-1:0]    host_wdata,
  output logic [`REGMAN_DATA_W-1:0]    host_rdata
);

  // sequencer to manager
  reg_op_e                      reg_op;
  logic                         op_done;
  logic [`REGMAN_DATA_W-1:0]    caught_value;
  logic [`REGMAN_ADDR_W-1:0]    lat_base;
  logic [`REGMAN_REG_NUM_W-1:0] lat_reg;
  logic                         lat_ptr;
  logic [1:0]                   lat_flags;
  logic [`REGMAN_DATA_W-1:0]    lat_store;

  // manager to bus port and back
  logic                      read_q;
  logic                      write_q;
  logic [`REGMAN_ADDR_W-1:0] addr;
  logic [`REGMAN_DATA_W-1:0] wdata;
  logic                      read_dn;
  logic                      write_dn;
  logic [`REGMAN_DATA_W-1:0] rdata;
  logic                      bus_busy;

  // bus port to memory
  logic                      mem_we;
  logic [`REGMAN_ADDR_W-1:0] mem_addr;
  logic [`REGMAN_DATA_W-1:0] mem_wdata;
  logic [`REGMAN_DATA_W-1:0] mem_rdata;

  operand_sequencer u_seq (
    .clk          (clk),
    .rst          (rst),
    .start        (start),
    .cmd_op       (cmd_op),
    .base_addr    (base_addr),
    .reg_num      (reg_num),
    .is_ptr       (is_ptr),
    .post_flags   (post_flags),
    .store_data   (store_data),
    .op_done      (op_done),
    .caught_value (caught_value),
    .reg_op       (reg_op),
    .lat_base     (lat_base),
    .lat_reg      (lat_reg),
    .lat_ptr      (lat_ptr),
    .lat_flags    (lat_flags),
    .lat_store    (lat_store),
    .busy         (busy),
    .done         (done),
    .result       (result)
  );

  // manager works on the latched command
  register_manager u_mgr (
    .clk          (clk),
    .rst          (rst),
    .reg_op       (reg_op),
    .base_addr    (lat_base),
    .reg_num      (lat_reg),
    .is_ptr       (lat_ptr),
    .post_flags   (lat_flags),
    .store_data   (lat_store),
    .read_dn      (read_dn),
    .write_dn     (write_dn),
    .rdata        (rdata),
    .bus_busy     (bus_busy),
    .read_q       (read_q),
    .write_q      (write_q),
    .addr         (addr),
    .wdata        (wdata),
    .op_done      (op_done),
    .caught_value (caught_value)
  );

  bus_port u_bus (
    .clk       (clk),
    .rst       (rst),
    .read_q    (read_q),
    .write_q   (write_q),
    .addr      (addr),
    .wdata     (wdata),
    .mem_rdata (mem_rdata),
    .read_dn   (read_dn),
    .write_dn  (write_dn),
    .rdata     (rdata),
    .bus_busy  (bus_busy),
    .mem_we    (mem_we),
    .mem_addr  (mem_addr),
    .mem_wdata (mem_wdata)
  );

  register_memory u_mem (
    .clk        (clk),
    .host_we    (host_we),
    .host_addr  (host_addr),
    .host_wdata (host_wdata),
    .mem_we     (mem_we),
    .mem_addr   (mem_addr),
    .mem_wdata  (mem_wdata),
    .host_rdata (host_rdata),
    .mem_rdata  (mem_rdata)
  );

endmodule

// ==== tb_regman.sv ====
`include "regman_cfg.svh"

module tb_regman
  import regman_pkg::*;
();

  localparam int dw = `REGMAN_DATA_W;
  localparam int aw = `REGMAN_ADDR_W;
  localparam int rw = `REGMAN_REG_NUM_W;
  localparam int wait_limit = 200;

  logic          clk;
  logic          rst;
  logic          start;
  cmd_op_e       cmd_op;
  logic [aw-1:0] base_addr;
  logic [rw-1:0] reg_num;
  logic          is_ptr;
  logic [1:0]    post_flags;
  logic [dw-1:0] store_data;
  logic          busy;
  logic          done;
  logic [dw-1:0] result;
  logic          host_we;
  logic [aw-1:0] host_addr;
  logic [dw-1:0] host_wdata;
  logic [dw-1:0] host_rdata;

  // shadow of the word memory, follows every command
  logic [dw-1:0] shadow [1 << aw];
  // expectations in command order
  logic [dw-1:0] exp_results [$];
  cmd_op_e       exp_ops [$];
  string         exp_names [$];

  logic [31:0] rng_state;
  int          error_count;
  int          accepted_count;
  int          done_count;

  regman_top i_dut (
    .clk        (clk),
    .rst        (rst),
    .start      (start),
    .cmd_op     (cmd_op),
    .base_addr  (base_addr),
    .reg_num    (reg_num),
    .is_ptr     (is_ptr),
    .post_flags (post_flags),
    .store_data (store_data),
    .busy       (busy),
    .done       (done),
    .result     (result),
    .host_we    (host_we),
    .host_addr  (host_addr),
    .host_wdata (host_wdata),
    .host_rdata (host_rdata)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // xorshift32
  function automatic logic [31:0] next_rand();
    rng_state = rng_state ^ (rng_state << 13);
    rng_state = rng_state ^ (rng_state >> 17);
    rng_state = rng_state ^ (rng_state << 5);
    return rng_state;
  endfunction

  // 01 counts up, 10 counts down, 00 and 11 keep the word
  function automatic logic [dw-1:0] flag_update(input logic [dw-1:0] value,
                                                input logic [1:0]    flags);
    if (flags == 2'b01) begin
      return value + dw'(1);
    end else if (flags == 2'b10) begin
      return value - dw'(1);
    end
    return value;
  endfunction

  // expected operand, shadow memory updated in sequence order
  function automatic logic [dw-1:0] reference_result(input cmd_op_e       op,
                                                     input logic [aw-1:0] base,
                                                     input logic [rw-1:0] rnum,
                                                     input logic          ptr,
                                                     input logic [1:0]    flags,
                                                     input logic [dw-1:0] sdata);
    logic [aw-1:0] reg_addr;
    logic [aw-1:0] ptr_addr;
    logic [dw-1:0] p;
    logic [dw-1:0] value;
    reg_addr = base + aw'(rnum);
    // direct store ignores the flags
    if (op == CMD_STORE && !ptr) begin
      shadow[reg_addr] = sdata;
      return sdata;
    end
    p = shadow[reg_addr];
    if (!ptr) begin
      value = p;
    end else begin
      ptr_addr = base + p[aw-1:0];
      if (op == CMD_FETCH) begin
        value = shadow[ptr_addr];
      end else begin
        shadow[ptr_addr] = sdata;
        value = sdata;
      end
    end
    // write-back only for 01 and 10, may overwrite a store through itself
    if (^flags) begin
      shadow[reg_addr] = flag_update(p, flags);
    end
    return value;
  endfunction

  task automatic stop_on_error(input string msg);
    error_count++;
    $display("%s", msg);
    $display("Test failures found");
    $fatal(1, "simulation stopped at first error");
  endtask

  task automatic report_timeout(input string what);
    stop_on_error($sformatf("timeout after %0d cycles waiting for %s", wait_limit, what));
  endtask

  task automatic check_word(input string name, input logic [dw-1:0] expected,
                            input logic [dw-1:0] actual);
    if (actual !== expected) begin
      stop_on_error($sformatf("FAIL %s: expected %h, actual %h", name, expected, actual));
    end
  endtask

  task automatic check_op(input string name, input cmd_op_e expected, input cmd_op_e actual);
    if (actual !== expected) begin
      stop_on_error($sformatf("FAIL %s: expected %s, actual %s", name, expected.name(),
                              actual.name()));
    end
  endtask

  task automatic check_count(input string name, input int expected, input int actual);
    if (actual != expected) begin
      stop_on_error($sformatf("FAIL %s: expected %0d, actual %0d", name, expected, actual));
    end
  endtask

  // result and latched opcode on every done pulse
  always @(negedge clk) begin : compare_results
    string         name;
    logic [dw-1:0] exp_val;
    cmd_op_e       exp_op;
    if (!rst && done) begin
      done_count++;
      if (exp_results.size() == 0) begin
        stop_on_error("done pulse seen with no command outstanding");
      end else begin
        name    = exp_names.pop_front();
        exp_val = exp_results.pop_front();
        exp_op  = exp_ops.pop_front();
        check_word(name, exp_val, result);
        check_op({name, " opcode"}, exp_op, i_dut.u_seq.lat_op);
      end
    end
  end

  task automatic host_write(input logic [aw-1:0] addr, input logic [dw-1:0] data);
    @(posedge clk);
    #2;
    host_we    = 1'b1;
    host_addr  = addr;
    host_wdata = data;
    @(posedge clk);
    #2;
    host_we = 1'b0;
  endtask

  // sync read, data shows one edge later
  task automatic host_read(input logic [aw-1:0] addr, output logic [dw-1:0] data);
    @(posedge clk);
    #2;
    host_addr = addr;
    @(posedge clk);
    @(negedge clk);
    data = host_rdata;
  endtask

  task automatic preload_word(input logic [aw-1:0] addr, input logic [dw-1:0] data);
    host_write(addr, data);
    shadow[addr] = data;
  endtask

  task automatic check_at(input string name, input logic [aw-1:0] addr);
    logic [dw-1:0] got;
    host_read(addr, got);
    check_word($sformatf("%s @%h", name, addr), shadow[addr], got);
  endtask

  task automatic check_memory(input string name);
    for (int a = 0; a < (1 << aw); a++) begin
      check_at(name, aw'(a));
    end
  endtask

  task automatic wait_idle();
    int cycles;
    cycles = 0;
    @(negedge clk);
    while (busy) begin
      if (cycles >= wait_limit) report_timeout("busy to drop");
      cycles++;
      @(negedge clk);
    end
  endtask

  task automatic wait_done();
    int cycles;
    cycles = 0;
    @(negedge clk);
    while (!done) begin
      if (cycles >= wait_limit) report_timeout("done pulse");
      cycles++;
      @(negedge clk);
    end
  endtask

  // one start strobe, expectation queued first
  task automatic send_command(input string name, input cmd_op_e op, input logic [aw-1:0] base,
                              input logic [rw-1:0] rnum, input logic ptr,
                              input logic [1:0] flags, input logic [dw-1:0] sdata);
    exp_results.push_back(reference_result(op, base, rnum, ptr, flags, sdata));
    exp_ops.push_back(op);
    exp_names.push_back(name);
    @(posedge clk);
    #2;
    start      = 1'b1;
    cmd_op     = op;
    base_addr  = base;
    reg_num    = rnum;
    is_ptr     = ptr;
    post_flags = flags;
    store_data = sdata;
    @(posedge clk);
    #2;
    start = 1'b0;
    accepted_count++;
  endtask

  task automatic run_command(input string name, input cmd_op_e op, input logic [aw-1:0] base,
                             input logic [rw-1:0] rnum, input logic ptr,
                             input logic [1:0] flags, input logic [dw-1:0] sdata);
    wait_idle();
    send_command(name, op, base, rnum, ptr, flags, sdata);
    wait_done();
  endtask

  task automatic random_command(input int idx);
    logic [31:0] r;
    logic [31:0] d;
    cmd_op_e     op;
    r  = next_rand();
    d  = next_rand();
    op = r[0] ? CMD_STORE : CMD_FETCH;
    run_command($sformatf("random %0d", idx), op, r[15:8], r[19:16], r[1], r[3:2], d[dw-1:0]);
  endtask

  initial begin : main
    logic [31:0]   r;
    logic [aw-1:0] target;
    rng_state      = 32'h7452;
    error_count    = 0;
    accepted_count = 0;
    done_count     = 0;
    rst            = 1'b1;
    start          = 1'b0;
    cmd_op         = CMD_FETCH;
    base_addr      = '0;
    reg_num        = '0;
    is_ptr         = 1'b0;
    post_flags     = 2'b00;
    store_data     = '0;
    host_we        = 1'b0;
    host_addr      = '0;
    host_wdata     = '0;
    repeat (8) @(posedge clk);
    #2;
    rst = 1'b0;

    // quiet after reset
    repeat (4) begin
      @(negedge clk);
      if (busy || done) stop_on_error("busy or done went high with no command after reset");
    end
    // random fill, every address gets its own word
    for (int a = 0; a < (1 << aw); a++) begin
      r = next_rand();
      preload_word(aw'(a), r[dw-1:0]);
    end
    check_memory("host readback");

    // direct fetch, all four flag codes
    for (int f = 0; f < 4; f++) begin
      run_command($sformatf("direct fetch flags %b", 2'(f)), CMD_FETCH, 8'h40, 4'h3, 1'b0,
                  2'(f), '0);
      check_at("direct fetch write-back", 8'h43);
    end

    // pointer fetch, target wraps past the top of memory
    preload_word(8'hf5, 16'h0012);
    for (int f = 0; f < 4; f++) begin
      target = 8'hf0 + shadow[8'hf5][aw-1:0];
      run_command($sformatf("pointer fetch flags %b", 2'(f)), CMD_FETCH, 8'hf0, 4'h5, 1'b1,
                  2'(f), '0);
      check_at("pointer fetch pointer", 8'hf5);
      check_at("pointer fetch target", target);
    end
    // all-ones pointer rolls over to zero
    preload_word(8'hf5, 16'hffff);
    run_command("pointer fetch rollover", CMD_FETCH, 8'hf0, 4'h5, 1'b1, 2'b01, '0);
    check_at("pointer rollover", 8'hf5);

    // direct store, flags have no effect
    run_command("direct store", CMD_STORE, 8'h80, 4'ha, 1'b0, 2'b01, 16'h5a3c);
    check_at("direct store target", 8'h8a);
    // pointer store, up then down
    preload_word(8'h21, 16'h0030);
    for (int f = 1; f < 3; f++) begin
      r      = next_rand();
      target = 8'h20 + shadow[8'h21][aw-1:0];
      run_command($sformatf("pointer store flags %b", 2'(f)), CMD_STORE, 8'h20, 4'h1, 1'b1,
                  2'(f), r[dw-1:0]);
      check_at("pointer store pointer", 8'h21);
      check_at("pointer store target", target);
    end
    // pointer aimed at itself, write-back lands last
    preload_word(8'h21, 16'h0001);
    run_command("pointer store self", CMD_STORE, 8'h20, 4'h1, 1'b1, 2'b01, 16'hbeef);
    check_at("pointer store self", 8'h21);

    // start while busy must be dropped
    wait_idle();
    send_command("busy accepted", CMD_FETCH, 8'h10, 4'h7, 1'b1, 2'b10, '0);
    @(negedge clk);
    if (!busy) stop_on_error("busy did not rise after an accepted start");
    @(posedge clk);
    #2;
    start      = 1'b1;
    cmd_op     = CMD_STORE;
    base_addr  = 8'h60;
    reg_num    = 4'h2;
    is_ptr     = 1'b0;
    store_data = 16'hdead;
    @(posedge clk);
    #2;
    start = 1'b0;
    wait_done();
    wait_idle();
    check_count("done pulses vs accepted starts", accepted_count, done_count);
    check_memory("memory after ignored start");

    // random commands
    for (int i = 0; i < 200; i++) begin
      random_command(i);
    end
    wait_idle();
    check_count("final done pulses", accepted_count, done_count);
    check_memory("memory after random run");

    if (error_count == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule

// ==== list.f ====
+incdir+.
regman_pkg.sv
operand_sequencer.sv
register_manager.sv
bus_port.sv
register_memory.sv
regman_top.sv
tb_regman.sv

// ==== Bender.yml ====
package:
  name: regman

sources:
  - include_dirs:
      - .
    files:
      - regman_pkg.sv
      - operand_sequencer.sv
      - register_manager.sv
      - bus_port.sv
      - register_memory.sv
      - regman_top.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_regman.sv
